// File: Makefile
# Verilator build and run of the multiply/divide unit testbench
TOP = imuldiv_unit_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: bench/imuldiv_unit_tb.sv
// testbench for the iterative multiply/divide unit
// reference model, handshake tasks, concurrent checks on latency and back-pressure

`timescale 1ns/1ps

module imuldiv_unit_tb;

  // cycles any single wait may take before it is treated as a hang
  localparam int wait_limit = 100;

  logic                     clk;
  logic                     reset;
  imuldiv_pkg::req_msg_t    req_msg;
  logic                     req_val;
  logic                     req_rdy;
  imuldiv_pkg::resp_msg_t   resp_msg;
  logic                     resp_val;
  logic                     resp_rdy;

  int                       seed;
  int                       errors;
  int                       pass_count;
  int                       fail_count;
  imuldiv_pkg::resp_msg_t   exp_q[$];
  logic [31:0]              corners [4];

  // protocol tracking, sampled by the concurrent checks
  logic                     busy;
  int                       since_acc;
  logic                     held;
  imuldiv_pkg::resp_msg_t   held_msg;
  imuldiv_pkg::ctrl_state_t dut_state;

  imuldiv_unit u_imuldiv_unit (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // controller state, only for failure messages
  assign dut_state = u_imuldiv_unit.u_ctrl.state;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // protocol tracking and concurrent checks
  // --------------------------------------------------------------------------

  // since_acc holds k when edge k after the accepting edge is sampled
  always @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      since_acc <= 0;
      held      <= 1'b0;
      held_msg  <= '0;
    end else begin
      if (req_val && req_rdy) begin
        busy      <= 1'b1;
        since_acc <= 1;
      end else if (busy) begin
        since_acc <= since_acc + 1;
        if (resp_val && resp_rdy) begin
          busy <= 1'b0;
        end
      end
      // response stalled on this edge, must be unchanged on the next one
      held     <= resp_val && !resp_rdy;
      held_msg <= resp_msg;
    end
  end

  latency_early: assert property (@(posedge clk) disable iff (reset)
    (busy && since_acc < 33) |-> !resp_val)
    else begin
      $display("** Error at %0t: resp_val expected 0 got 1 at edge %0d, state %s",
               $time, $sampled(since_acc), dut_state.name());
      errors++;
    end

  latency_exact: assert property (@(posedge clk) disable iff (reset)
    (busy && since_acc == 33) |-> resp_val)
    else begin
      $display("** Error at %0t: resp_val expected 1 got 0 at edge 33, state %s",
               $time, dut_state.name());
      errors++;
    end

  // no new request while one is in flight
  busy_rdy: assert property (@(posedge clk) disable iff (reset) busy |-> !req_rdy)
    else begin
      $display("** Error at %0t: req_rdy expected 0 got 1 while busy", $time);
      errors++;
    end

  stall_val: assert property (@(posedge clk) disable iff (reset) held |-> resp_val)
    else begin
      $display("** Error at %0t: resp_val expected 1 got 0 under back-pressure", $time);
      errors++;
    end

  stall_msg: assert property (@(posedge clk) disable iff (reset)
    held |-> (resp_msg == held_msg))
    else begin
      $display("** Error at %0t: resp_msg expected %h got %h under back-pressure",
               $time, $sampled(held_msg), $sampled(resp_msg));
      errors++;
    end

  // --------------------------------------------------------------------------
  // reference model and helpers
  // --------------------------------------------------------------------------

  // full product, or remainder:quotient with the zero divisor rule
  function automatic imuldiv_pkg::resp_msg_t ref_result(input imuldiv_pkg::op_t op,
                                                        input logic [31:0] a,
                                                        input logic [31:0] b);
    logic signed [63:0]     sa;
    logic signed [63:0]     sb;
    logic signed [63:0]     sq;
    logic signed [63:0]     sr;
    logic [63:0]            ua;
    logic [63:0]            ub;
    imuldiv_pkg::resp_msg_t res;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'd0, a};
    ub = {32'd0, b};
    // 64-bit signed math keeps most negative / -1 from overflowing
    case (op)
      imuldiv_pkg::op_mul:  res = sa * sb;
      imuldiv_pkg::op_mulu: res = ua * ub;
      default: begin
        if (b == 32'd0) begin
          res.hi = a;
          res.lo = 32'hffff_ffff;
        end else if (op == imuldiv_pkg::op_div) begin
          sq     = sa / sb;
          sr     = sa % sb;
          res.hi = sr[31:0];
          res.lo = sq[31:0];
        end else begin
          res.hi = 32'(ua % ub);
          res.lo = 32'(ua / ub);
        end
      end
    endcase
    return res;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    assert (act === exp)
      else begin
        $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        errors++;
      end
  endtask

  task automatic report_test(input string name, input int mark);
    if (errors == mark) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", name, errors - mark);
    end
  endtask

  // --------------------------------------------------------------------------
  // handshake tasks
  // --------------------------------------------------------------------------

  task automatic send_req(input imuldiv_pkg::op_t op, input logic [31:0] a,
                          input logic [31:0] b);
    int                    t;
    logic                  got;
    imuldiv_pkg::req_msg_t msg;
    msg.op  = op;
    msg.a   = a;
    msg.b   = b;
    req_msg <= msg;
    req_val <= 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      got = req_rdy;
      t++;
    end while (!got && t < wait_limit);
    req_val <= 1'b0;
    if (got) begin
      exp_q.push_back(ref_result(op, a, b));
    end else begin
      $display("request was never accepted within %0d cycles", wait_limit);
      errors++;
    end
  endtask

  task automatic wait_resp_val();
    int t;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!resp_val && t < wait_limit);
    if (!resp_val) begin
      $display("no response became valid within %0d cycles", wait_limit);
      errors++;
    end
  endtask

  task automatic recv_resp();
    int                     t;
    logic                   got;
    imuldiv_pkg::resp_msg_t exp;
    resp_rdy <= 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      got = resp_val && resp_rdy;
      t++;
    end while (!got && t < wait_limit);
    if (!got) begin
      $display("response transfer did not happen within %0d cycles", wait_limit);
      errors++;
    end else if (exp_q.size() == 0) begin
      $display("response arrived with no request outstanding");
      errors++;
    end else begin
      exp = exp_q.pop_front();
      check_val("resp_msg.hi", exp.hi, resp_msg.hi);
      check_val("resp_msg.lo", exp.lo, resp_msg.lo);
    end
  endtask

  task automatic run_op(input imuldiv_pkg::op_t op, input logic [31:0] a,
                        input logic [31:0] b);
    send_req(op, a, b);
    recv_resp();
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin
    int               mark;
    int               n;
    int               sh;
    logic [31:0]      ra;
    logic [31:0]      rb;
    imuldiv_pkg::op_t op;
    seed       = 32'h464d_c1fa;
    errors     = 0;
    pass_count = 0;
    fail_count = 0;
    corners    = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
    reset    <= 1'b1;
    req_val  <= 1'b0;
    req_msg  <= '0;
    resp_rdy <= 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // first edge with reset low
    mark = errors;
    @(posedge clk);
    check_val("req_rdy", 32'd1, 32'(req_rdy));
    check_val("resp_val", 32'd0, 32'(resp_val));
    report_test("reset", mark);

    mark = errors;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        run_op(imuldiv_pkg::op_mul, corners[i], corners[j]);
        run_op(imuldiv_pkg::op_mulu, corners[i], corners[j]);
      end
    end
    for (int i = 0; i < 20; i++) begin
      ra = $random(seed);
      rb = $random(seed);
      run_op(imuldiv_pkg::op_mul, ra, rb);
      run_op(imuldiv_pkg::op_mulu, ra, rb);
    end
    report_test("multiply", mark);

    mark = errors;
    run_op(imuldiv_pkg::op_div, 32'h8000_0000, 32'hffff_ffff);
    run_op(imuldiv_pkg::op_divu, 32'hffff_ffff, 32'h0000_0001);
    for (int i = 0; i < 24; i++) begin
      ra = $random(seed);
      rb = $random(seed);
      // small divisors on even passes, some of them negated
      if (i % 2 == 0) begin
        sh = {$random(seed)} % 32;
        rb = rb >> sh;
        if (i % 4 == 0) begin
          rb = -rb;
        end
      end
      if (rb == 32'd0) begin
        rb = 32'd3;
      end
      run_op(imuldiv_pkg::op_div, ra, rb);
      run_op(imuldiv_pkg::op_divu, ra, rb);
    end
    report_test("divide", mark);

    mark = errors;
    for (int i = 0; i < 4; i++) begin
      run_op(imuldiv_pkg::op_div, corners[i], 32'd0);
      run_op(imuldiv_pkg::op_divu, corners[i], 32'd0);
    end
    ra = $random(seed);
    run_op(imuldiv_pkg::op_div, ra, 32'd0);
    run_op(imuldiv_pkg::op_divu, ra, 32'd0);
    report_test("divide by zero", mark);

    // latency and busy are watched by the concurrent checks on every op
    mark = errors;
    for (int i = 0; i < 8; i++) begin
      ra = $random(seed);
      op = imuldiv_pkg::op_t'(ra[1:0]);
      run_op(op, $random(seed), $random(seed));
    end
    report_test("latency and busy", mark);

    mark = errors;
    for (int i = 0; i < 6; i++) begin
      ra = $random(seed);
      op = imuldiv_pkg::op_t'(ra[1:0]);
      n  = 1 + ({$random(seed)} % 20);
      resp_rdy <= 1'b0;
      send_req(op, $random(seed), $random(seed));
      wait_resp_val();
      repeat (n - 1) @(posedge clk);
      recv_resp();
      // the next request goes through normally
      run_op(imuldiv_pkg::op_mulu, $random(seed), $random(seed));
    end
    report_test("back-pressure", mark);

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: source/idiv_iterative_dpath.sv
// restoring divider datapath
// magnitude capture on load, one quotient bit per step, sign fixup and
// divide-by-zero override at the output

`timescale 1ns/1ps

module idiv_iterative_dpath (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [imuldiv_pkg::xlen-1:0]   a,
  input  logic [imuldiv_pkg::xlen-1:0]   b,
  input  imuldiv_pkg::dpath_ctrl_t       ctl,
  output imuldiv_pkg::resp_msg_t         result
);

  localparam int w = imuldiv_pkg::xlen;

  logic [w:0]   rem;
  logic [w-1:0] quo;
  logic [w-1:0] dvs;
  logic [w-1:0] dvd_orig;
  logic         q_neg;
  logic         r_neg;
  logic         div_zero;

  logic         sign_a;
  logic         sign_b;
  logic [w-1:0] mag_a;
  logic [w-1:0] mag_b;
  logic [w:0]   rem_sh;
  logic [w-1:0] quo_sh;
  logic [w+1:0] diff;
  logic [w-1:0] quo_fix;
  logic [w-1:0] rem_fix;

  // ------------------------------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------------------------------

  assign sign_a = ctl.is_signed && a[w-1];
  assign sign_b = ctl.is_signed && b[w-1];
  assign mag_a  = sign_a ? (~a + 1'b1) : a;
  assign mag_b  = sign_b ? (~b + 1'b1) : b;

  // ------------------------------------------------------------------------
  // one restoring step
  // ------------------------------------------------------------------------

  // shift remainder:quotient left, top quotient bit moves into the remainder
  assign rem_sh = {rem[w-1:0], quo[w-1]};
  assign quo_sh = {quo[w-2:0], 1'b0};

  // trial subtract, one extra bit so the sign is plain to see
  assign diff = {1'b0, rem_sh} - {2'b00, dvs};

  // flags and partial remainder
  always_ff @(posedge clk) begin
    if (reset) begin
      rem      <= '0;
      q_neg    <= 1'b0;
      r_neg    <= 1'b0;
      div_zero <= 1'b0;
    end else if (ctl.load) begin
      rem      <= '0;
      q_neg    <= sign_a ^ sign_b;
      // remainder takes the sign of the dividend
      r_neg    <= sign_a;
      div_zero <= (b == '0);
    end else if (ctl.step) begin
      if (diff[w+1]) begin
        // negative, restore
        rem <= rem_sh;
      end else begin
        rem <= diff[w:0];
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (ctl.load) begin
      quo      <= mag_a;
      dvs      <= mag_b;
      dvd_orig <= a;
    end else if (ctl.step) begin
      quo <= quo_sh | {{(w-1){1'b0}}, ~diff[w+1]};
    end
  end

  // ------------------------------------------------------------------------
  // output
  // ------------------------------------------------------------------------

  assign quo_fix = q_neg ? (~quo + 1'b1) : quo;
  assign rem_fix = r_neg ? (~rem[w-1:0] + 1'b1) : rem[w-1:0];

  // zero divisor: quotient all ones, remainder is the untouched dividend
  always_comb begin
    if (div_zero) begin
      result.hi = dvd_orig;
      result.lo = '1;
    end else begin
      result.hi = rem_fix;
      result.lo = quo_fix;
    end
  end

endmodule

// File: source/imul_iterative_dpath.sv
// shift-and-add multiplier datapath
// magnitude capture on load, one partial product per step, sign fixup at output

`timescale 1ns/1ps

module imul_iterative_dpath (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [imuldiv_pkg::xlen-1:0]   a,
  input  logic [imuldiv_pkg::xlen-1:0]   b,
  input  imuldiv_pkg::dpath_ctrl_t       ctl,
  output imuldiv_pkg::resp_msg_t         result
);

  localparam int w = imuldiv_pkg::xlen;

  logic [2*w-1:0] a_reg;
  logic [w-1:0]   b_reg;
  logic [2*w-1:0] acc;
  logic           neg;

  logic           sign_a;
  logic           sign_b;
  logic [w-1:0]   mag_a;
  logic [w-1:0]   mag_b;
  logic [2*w-1:0] acc_fix;

  // ------------------------------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------------------------------

  // sign bits only count for the signed opcode
  assign sign_a = ctl.is_signed && a[w-1];
  assign sign_b = ctl.is_signed && b[w-1];
  assign mag_a  = sign_a ? (~a + 1'b1) : a;
  assign mag_b  = sign_b ? (~b + 1'b1) : b;

  // ------------------------------------------------------------------------
  // iteration
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
      neg <= 1'b0;
    end else if (ctl.load) begin
      acc <= '0;
      neg <= sign_a ^ sign_b;
    end else if (ctl.step) begin
      // add the shifted multiplicand when the current multiplier bit is set
      if (b_reg[0]) begin
        acc <= acc + a_reg;
      end
    end
  end

  // operand shift registers
  always_ff @(posedge clk) begin
    if (ctl.load) begin
      a_reg <= {{w{1'b0}}, mag_a};
      b_reg <= mag_b;
    end else if (ctl.step) begin
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // ------------------------------------------------------------------------
  // output
  // ------------------------------------------------------------------------

  // negate the unsigned product when exactly one operand was negative
  assign acc_fix = neg ? (~acc + 1'b1) : acc;
  assign result  = imuldiv_pkg::resp_msg_t'(acc_fix);

endmodule

// File: source/imuldiv_ctrl.sv
// shared iterative controller for the multiply/divide datapaths
// idle/calc/done FSM, step counter, opcode decode and handshake outputs

`timescale 1ns/1ps

module imuldiv_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_pkg::op_t         req_op,
  input  logic                     req_val,
  output logic                     req_rdy,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output imuldiv_pkg::dpath_ctrl_t ctl
);

  imuldiv_pkg::ctrl_state_t state;
  logic [4:0]               count;
  logic                     div_q;
  logic                     signed_q;
  logic                     accept;
  logic                     resp_xfer;
  logic                     dec_div;
  logic                     dec_signed;

  // ------------------------------------------------------------------------
  // handshake
  // ------------------------------------------------------------------------

  assign req_rdy   = (state == imuldiv_pkg::st_idle);
  assign resp_val  = (state == imuldiv_pkg::st_done);
  assign accept    = req_val && req_rdy;
  assign resp_xfer = resp_val && resp_rdy;

  // opcode decode, only looked at on the accepting edge
  assign dec_div    = (req_op == imuldiv_pkg::op_div) || (req_op == imuldiv_pkg::op_divu);
  assign dec_signed = (req_op == imuldiv_pkg::op_mul) || (req_op == imuldiv_pkg::op_div);

  // ------------------------------------------------------------------------
  // state and counter
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= imuldiv_pkg::st_idle;
      count    <= 5'd0;
      div_q    <= 1'b0;
      signed_q <= 1'b0;
    end else begin
      case (state)
        imuldiv_pkg::st_idle: begin
          if (accept) begin
            state    <= imuldiv_pkg::st_calc;
            count    <= 5'd0;
            div_q    <= dec_div;
            signed_q <= dec_signed;
          end
        end
        imuldiv_pkg::st_calc: begin
          // 32 step cycles, counter wraps back to zero on the last one
          count <= count + 5'd1;
          if (count == 5'd31) begin
            state <= imuldiv_pkg::st_done;
          end
        end
        imuldiv_pkg::st_done: begin
          // hold the response until the consumer takes it
          if (resp_xfer) begin
            state <= imuldiv_pkg::st_idle;
          end
        end
        default: begin
          state <= imuldiv_pkg::st_idle;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // datapath control
  // ------------------------------------------------------------------------

  // during load the datapaths need the new opcode's flags, registered
  // copies take over from the next cycle onwards
  always_comb begin
    ctl.load      = accept;
    ctl.step      = (state == imuldiv_pkg::st_calc);
    ctl.is_div    = accept ? dec_div : div_q;
    ctl.is_signed = accept ? dec_signed : signed_q;
  end

endmodule

// File: source/imuldiv_pkg.sv
// shared definitions for the iterative multiply/divide unit
// operand width, opcode and state enums, message and control structs

package imuldiv_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------

  // operand width, also the number of iterations per operation
  localparam int xlen = 32;

  // ------------------------------------------------------------------------
  // enums
  // ------------------------------------------------------------------------

  // request opcodes
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_mulu = 2'd1,
    op_div  = 2'd2,
    op_divu = 2'd3
  } op_t;

  // controller states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } ctrl_state_t;

  // ------------------------------------------------------------------------
  // messages
  // ------------------------------------------------------------------------

  // request: opcode plus multiplicand/dividend and multiplier/divisor
  typedef struct packed {
    op_t             op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } req_msg_t;

  // response: product as hi:lo, or remainder in hi and quotient in lo
  typedef struct packed {
    logic [xlen-1:0] hi;
    logic [xlen-1:0] lo;
  } resp_msg_t;

  // controller to datapath bundle
  typedef struct packed {
    logic load;       // capture operands, take magnitudes
    logic step;       // one iteration
    logic is_div;     // divider selected
    logic is_signed;  // sign fixup applies
  } dpath_ctrl_t;

endpackage

// File: source/imuldiv_unit.sv
// top level of the iterative multiply/divide unit
// controller, multiplier and divider datapaths, response select

`timescale 1ns/1ps

module imuldiv_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  imuldiv_pkg::req_msg_t  req_msg,
  input  logic                   req_val,
  output logic                   req_rdy,
  output imuldiv_pkg::resp_msg_t resp_msg,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  imuldiv_pkg::dpath_ctrl_t ctl;
  imuldiv_pkg::resp_msg_t   mul_result;
  imuldiv_pkg::resp_msg_t   div_result;

  // one controller sequences whichever datapath the opcode picked
  imuldiv_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_op   (req_msg.op),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctl      (ctl)
  );

  // both datapaths see the same control, the unused one just idles along
  imul_iterative_dpath u_mul (
    .clk    (clk),
    .reset  (reset),
    .a      (req_msg.a),
    .b      (req_msg.b),
    .ctl    (ctl),
    .result (mul_result)
  );

  idiv_iterative_dpath u_div (
    .clk    (clk),
    .reset  (reset),
    .a      (req_msg.a),
    .b      (req_msg.b),
    .ctl    (ctl),
    .result (div_result)
  );

  // is_div is held by the controller until the next accept
  assign resp_msg = ctl.is_div ? div_result : mul_result;

endmodule

// File: vlog.f
source/imuldiv_pkg.sv
source/imuldiv_ctrl.sv
source/imul_iterative_dpath.sv
source/idiv_iterative_dpath.sv
source/imuldiv_unit.sv
bench/imuldiv_unit_tb.sv
